/* Bender.yml */
package:
  name: phy_mgmt

dependencies: {}

sources:
  # Packages first, the RTL depends on them
  - source/mdio_pkg.sv
  - source/phy_regs_pkg.sv
  # RTL
  - source/phy_init_sequencer.sv
  - source/mdio_master.sv
  - source/phy_mgmt_top.sv
  # Testbench
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_mdio_monitor.sv
      - verification/tb_phy_mgmt.sv

/* source/mdio_master.sv */
// MDIO write master: MDC divider and 64-bit clause-22 frame serializer
`timescale 1ns/1ps

module mdio_master (
    input  logic                clk_125mhz_int,
    input  logic                rst_125mhz_int,

    input  mdio_pkg::mdio_cmd_t cmd_i,
    input  logic                cmd_valid_i,
    output logic                cmd_ready_o,

    output logic                mdc_o,
    output logic                mdio_o,
    output logic                mdio_t_o
);

    logic                                busy_q;
    logic [mdio_pkg::PRESCALE_W-1:0]     pre_cnt;
    logic [mdio_pkg::BIT_COUNT_W-1:0]    bit_cnt;
    mdio_pkg::mdio_word_u                word_q;
    logic                                cmd_xfer;
    logic                                half_done;
    logic                                mdc_fall;
    logic                                in_preamble;
    logic                                last_bit;

    assign cmd_xfer  = cmd_valid_i && cmd_ready_o;
    assign half_done = busy_q && (int'(pre_cnt) == mdio_pkg::MDC_PRESCALE);
    assign mdc_fall  = half_done && mdc_o;

    // Next bit still lies in the preamble
    assign in_preamble = int'(bit_cnt) < mdio_pkg::PREAMBLE_BITS - 1;
    assign last_bit    = int'(bit_cnt) == mdio_pkg::PREAMBLE_BITS + mdio_pkg::FRAME_BITS - 1;

    // Bus is driven exactly while a frame is in flight
    assign cmd_ready_o = ~busy_q;
    assign mdio_t_o    = ~busy_q;

    // MDC generation and bit sequencing
    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            busy_q  <= 1'b0;
            pre_cnt <= '0;
            bit_cnt <= '0;
            mdc_o   <= 1'b0;
            mdio_o  <= 1'b1;
        end else if (cmd_xfer) begin
            busy_q  <= 1'b1;
            pre_cnt <= '0;
            bit_cnt <= '0;
            mdc_o   <= 1'b0;
            // First preamble one goes out with MDC low
            mdio_o  <= 1'b1;
        end else if (busy_q) begin
            if (half_done) begin
                pre_cnt <= '0;
                mdc_o   <= ~mdc_o;
                if (mdc_o) begin
                    // Falling MDC edge, move to the next bit
                    if (last_bit) begin
                        busy_q <= 1'b0;
                        mdio_o <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        mdio_o  <= in_preamble ? 1'b1 : word_q.raw[mdio_pkg::FRAME_BITS-1];
                    end
                end
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
            end
        end
    end

    // Frame word, loaded on acceptance and shifted MSB first after the preamble
    always_ff @(posedge clk_125mhz_int) begin
        if (cmd_xfer) begin
            word_q.frame <= '{
                st:       mdio_pkg::ST_CLAUSE22,
                op:       mdio_pkg::OP_WRITE,
                phy_addr: cmd_i.phy_addr,
                reg_addr: cmd_i.reg_addr,
                ta:       mdio_pkg::TA_WRITE,
                data:     cmd_i.data
            };
        end else if (mdc_fall && !in_preamble && !last_bit) begin
            word_q.raw <= word_q.raw << 1;
        end
    end

endmodule

/* source/mdio_pkg.sv */
// MDIO clause-22 frame constants, command struct, frame union and MDC timing
package mdio_pkg;

    // Frame layout
    localparam int PREAMBLE_BITS = 32;
    localparam int FRAME_BITS    = 32;

    localparam logic [1:0] ST_CLAUSE22 = 2'b01;
    localparam logic [1:0] OP_WRITE    = 2'b01;
    localparam logic [1:0] TA_WRITE    = 2'b10;

    // MDC half-period is MDC_PRESCALE + 1 clocks
    localparam int MDC_PRESCALE = 3;
    localparam int PRESCALE_W   = $clog2(MDC_PRESCALE + 1);

    // Counts preamble and frame bits together
    localparam int BIT_COUNT_W = $clog2(PREAMBLE_BITS + FRAME_BITS);

    // One register write as handed to the master
    typedef struct packed {
        logic [4:0]  phy_addr;
        logic [4:0]  reg_addr;
        logic [15:0] data;
    } mdio_cmd_t;

    // Frame after the preamble, MSB goes out first
    typedef struct packed {
        logic [1:0]  st;
        logic [1:0]  op;
        logic [4:0]  phy_addr;
        logic [4:0]  reg_addr;
        logic [1:0]  ta;
        logic [15:0] data;
    } mdio_frame_t;

    // Built through the fields, serialized through the raw bits
    typedef union packed {
        mdio_frame_t           frame;
        logic [FRAME_BITS-1:0] raw;
    } mdio_word_u;

endpackage

/* source/phy_init_sequencer.sv */
// PHY init sequencer: start-up delay, then 12 indirect extended register writes
`timescale 1ns/1ps

module phy_init_sequencer #(
    parameter int unsigned STARTUP_DELAY = phy_regs_pkg::INIT_DELAY_CYCLES
) (
    input  logic                clk_125mhz_int,
    input  logic                rst_125mhz_int,

    output mdio_pkg::mdio_cmd_t cmd_o,
    output logic                cmd_valid_o,
    input  logic                cmd_ready_i,

    output logic                done_o
);

    logic [phy_regs_pkg::DELAY_W-1:0]   delay_cnt;
    logic [phy_regs_pkg::REG_IDX_W-1:0] reg_idx;
    logic [1:0]                         phase;
    logic                               cmd_xfer;
    logic                               last_step;

    assign cmd_xfer  = cmd_valid_o && cmd_ready_i;
    assign last_step = (int'(reg_idx) == phy_regs_pkg::EXT_REG_COUNT - 1) && (phase == 2'd3);

    // Step control, advances only on a handshake
    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            delay_cnt   <= STARTUP_DELAY[phy_regs_pkg::DELAY_W-1:0];
            reg_idx     <= '0;
            phase       <= 2'd0;
            cmd_valid_o <= 1'b0;
            done_o      <= 1'b0;
        end else if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
            // First command shows up as the count expires
            if (int'(delay_cnt) == 1) begin
                cmd_valid_o <= 1'b1;
            end
        end else if (!done_o) begin
            if (!cmd_valid_o) begin
                // Only reached with a zero start-up delay
                cmd_valid_o <= 1'b1;
            end else if (cmd_xfer) begin
                if (last_step) begin
                    cmd_valid_o <= 1'b0;
                    done_o      <= 1'b1;
                end else begin
                    phase <= phase + 2'd1;
                    if (phase == 2'd3) begin
                        reg_idx <= reg_idx + 1'b1;
                    end
                end
            end
        end
    end

    // Four writes per extended register through REGCR/ADDAR
    always_comb begin
        cmd_o.phy_addr = phy_regs_pkg::PHY_ADDR;
        case (phase)
            2'd0: begin
                cmd_o.reg_addr = phy_regs_pkg::REG_REGCR;
                cmd_o.data     = phy_regs_pkg::REGCR_ADDR_MODE;
            end
            2'd1: begin
                cmd_o.reg_addr = phy_regs_pkg::REG_ADDAR;
                cmd_o.data     = phy_regs_pkg::EXT_INIT_TABLE[reg_idx].addr;
            end
            2'd2: begin
                cmd_o.reg_addr = phy_regs_pkg::REG_REGCR;
                cmd_o.data     = phy_regs_pkg::REGCR_DATA_MODE;
            end
            default: begin
                cmd_o.reg_addr = phy_regs_pkg::REG_ADDAR;
                cmd_o.data     = phy_regs_pkg::EXT_INIT_TABLE[reg_idx].value;
            end
        endcase
    end

endmodule

/* source/phy_mgmt_top.sv */
// PHY management top: init sequencer feeding the MDIO write master
`timescale 1ns/1ps

module phy_mgmt_top #(
    parameter int unsigned STARTUP_DELAY = phy_regs_pkg::INIT_DELAY_CYCLES
) (
    input  logic clk_125mhz_int,
    input  logic rst_125mhz_int,

    // MDIO pins, pad tri-state sits at board level
    output logic mdc_o,
    output logic mdio_o,
    output logic mdio_t_o,

    output logic done_o
);

    mdio_pkg::mdio_cmd_t cmd;
    logic                cmd_valid;
    logic                cmd_ready;

    phy_init_sequencer #(
        .STARTUP_DELAY (STARTUP_DELAY)
    ) seq0 (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .cmd_o          (cmd),
        .cmd_valid_o    (cmd_valid),
        .cmd_ready_i    (cmd_ready),
        .done_o         (done_o)
    );

    mdio_master mdio0 (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .cmd_i          (cmd),
        .cmd_valid_i    (cmd_valid),
        .cmd_ready_o    (cmd_ready),
        .mdc_o          (mdc_o),
        .mdio_o         (mdio_o),
        .mdio_t_o       (mdio_t_o)
    );

endmodule

/* source/phy_regs_pkg.sv */
// Copper PHY register map, extended register init table and start-up delay
package phy_regs_pkg;

    // MDIO address of the PHY on the board
    localparam logic [4:0] PHY_ADDR = 5'd3;

    // Clause-22 registers used for indirect extended access
    localparam logic [4:0] REG_REGCR = 5'h0D;
    localparam logic [4:0] REG_ADDAR = 5'h0E;

    // REGCR function codes for device address 1F
    localparam logic [15:0] REGCR_ADDR_MODE = 16'h001F;
    localparam logic [15:0] REGCR_DATA_MODE = 16'h401F;

    localparam int EXT_REG_COUNT = 3;
    localparam int REG_IDX_W     = $clog2(EXT_REG_COUNT);

    // Extended register address and the value written to it
    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] value;
    } ext_write_t;

    // Written in this order after start-up
    localparam ext_write_t EXT_INIT_TABLE [EXT_REG_COUNT] = '{
        // CFG4, SGMII auto-negotiation timer to 11 ms
        '{addr: 16'h0031, value: 16'h0070},
        // SGMIICTL1, SGMII clock output enable
        '{addr: 16'h00D3, value: 16'h4000},
        // 10M_SGMII_CFG, 10 Mbps operation over SGMII
        '{addr: 16'h016F, value: 16'h0015}
    };

    // Roughly 8 ms at 125 MHz before the first write
    localparam int unsigned INIT_DELAY_CYCLES = 1048575;
    localparam int          DELAY_W           = 20;

endpackage

/* sources.f */
source/mdio_pkg.sv
source/phy_regs_pkg.sv
source/phy_init_sequencer.sv
source/mdio_master.sv
source/phy_mgmt_top.sv
verification/tb_clk_gen.sv
verification/tb_mdio_monitor.sv
verification/tb_phy_mgmt.sv

/* verification/tb_clk_gen.sv */
// Testbench clock and power-on reset generator
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Reset held for a fixed number of rising edges
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

/* verification/tb_mdio_monitor.sv */
// MDIO bus monitor: samples MDIO on MDC rising edges and rebuilds write frames
`timescale 1ns/1ps

module tb_mdio_monitor (
    input  logic                  clk_i,
    input  logic                  rst_i,

    input  logic                  mdc_i,
    input  logic                  mdio_i,
    input  logic                  mdio_t_i,

    output logic                  frame_valid_o,
    output mdio_pkg::mdio_frame_t frame_o,
    output logic                  preamble_ok_o,
    output int                    bit_count_o
);

    localparam int TOTAL_BITS = mdio_pkg::PREAMBLE_BITS + mdio_pkg::FRAME_BITS;

    logic                  mdc_q;
    logic                  mdio_t_q;
    logic [TOTAL_BITS-1:0] shift_q;
    int                    bits_q;
    logic                  mdc_rise;
    logic                  frame_end;
    mdio_pkg::mdio_word_u  word;

    // Everything is sampled on the system clock, MDC is much slower
    assign mdc_rise  = mdc_i && !mdc_q && !mdio_t_i;
    assign frame_end = mdio_t_i && !mdio_t_q;

    // Last 32 bits on the wire, read back through the field view
    always_comb begin
        word.raw = shift_q[mdio_pkg::FRAME_BITS-1:0];
    end

    always_ff @(posedge clk_i) begin
        frame_valid_o <= 1'b0;
        if (rst_i) begin
            // An aborted frame is dropped
            mdc_q         <= 1'b0;
            mdio_t_q      <= 1'b1;
            shift_q       <= '0;
            bits_q        <= 0;
            frame_o       <= '0;
            preamble_ok_o <= 1'b0;
            bit_count_o   <= 0;
        end else begin
            mdc_q    <= mdc_i;
            mdio_t_q <= mdio_t_i;
            if (mdc_rise) begin
                shift_q <= {shift_q[TOTAL_BITS-2:0], mdio_i};
                bits_q  <= bits_q + 1;
            end
            // Bus released, the frame is complete
            if (frame_end) begin
                frame_valid_o <= 1'b1;
                frame_o       <= word.frame;
                preamble_ok_o <= &shift_q[TOTAL_BITS-1:mdio_pkg::FRAME_BITS];
                bit_count_o   <= bits_q;
                bits_q        <= 0;
            end
        end
    end

endmodule

/* verification/tb_phy_mgmt.sv */
// Testbench top: expected frame table, reset stimulus table, LFSR, checks, watchdog
`timescale 1ns/1ps

module tb_phy_mgmt;

    localparam int unsigned STARTUP_DELAY = 200;
    localparam int FRAME_COUNT    = 4 * phy_regs_pkg::EXT_REG_COUNT;
    localparam int TOTAL_BITS     = mdio_pkg::PREAMBLE_BITS + mdio_pkg::FRAME_BITS;
    localparam int TIMEOUT_CYCLES = 2 * (STARTUP_DELAY + FRAME_COUNT * 530);
    localparam int QUIET_CYCLES   = 1000;
    localparam int RESET_CYCLES   = 5;
    // Clocks into the chosen frame before the mid-sequence reset
    localparam int ABORT_OFFSET   = 100;
    localparam logic [15:0] LFSR_SEED = 16'd21608;

    typedef struct {
        string name;
        logic  mid_reset;
    } stim_t;

    logic                  clk_125mhz_int;
    logic                  por_rst;
    logic                  tb_rst;
    logic                  dut_rst;
    logic                  mdc;
    logic                  mdio;
    logic                  mdio_t;
    logic                  done;
    logic                  mon_valid;
    mdio_pkg::mdio_frame_t mon_frame;
    logic                  mon_preamble_ok;
    int                    mon_bits;
    int                    run_cycles;

    mdio_pkg::mdio_frame_t expected [FRAME_COUNT];
    stim_t                 stim_table [2];

    assign dut_rst = por_rst | tb_rst;

    tb_clk_gen #(
        .PERIOD_NS    (8.0),
        .RESET_CYCLES (RESET_CYCLES)
    ) clk_gen0 (
        .clk_o (clk_125mhz_int),
        .rst_o (por_rst)
    );

    phy_mgmt_top #(
        .STARTUP_DELAY (STARTUP_DELAY)
    ) dut0 (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (dut_rst),
        .mdc_o          (mdc),
        .mdio_o         (mdio),
        .mdio_t_o       (mdio_t),
        .done_o         (done)
    );

    tb_mdio_monitor mon0 (
        .clk_i         (clk_125mhz_int),
        .rst_i         (dut_rst),
        .mdc_i         (mdc),
        .mdio_i        (mdio),
        .mdio_t_i      (mdio_t),
        .frame_valid_o (mon_valid),
        .frame_o       (mon_frame),
        .preamble_ok_o (mon_preamble_ok),
        .bit_count_o   (mon_bits)
    );

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_frame(input string name, input mdio_pkg::mdio_frame_t exp,
                               input mdio_pkg::mdio_frame_t act);
        if (act !== exp) begin
            stop_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("Fail %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            stop_run($sformatf("Fail %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // REGCR addr mode, ADDAR addr, REGCR data mode, ADDAR value per register
    function automatic void build_tables();
        mdio_pkg::mdio_frame_t f;
        for (int r = 0; r < phy_regs_pkg::EXT_REG_COUNT; r++) begin
            for (int ph = 0; ph < 4; ph++) begin
                f.st       = mdio_pkg::ST_CLAUSE22;
                f.op       = mdio_pkg::OP_WRITE;
                f.phy_addr = phy_regs_pkg::PHY_ADDR;
                f.ta       = mdio_pkg::TA_WRITE;
                f.reg_addr = (ph % 2 == 0) ? phy_regs_pkg::REG_REGCR : phy_regs_pkg::REG_ADDAR;
                case (ph)
                    0: f.data = phy_regs_pkg::REGCR_ADDR_MODE;
                    1: f.data = phy_regs_pkg::EXT_INIT_TABLE[r].addr;
                    2: f.data = phy_regs_pkg::REGCR_DATA_MODE;
                    default: f.data = phy_regs_pkg::EXT_INIT_TABLE[r].value;
                endcase
                expected[4 * r + ph] = f;
            end
        end
        stim_table[0] = '{name: "straight_run", mid_reset: 1'b0};
        stim_table[1] = '{name: "mid_reset_run", mid_reset: 1'b1};
    endfunction

    // Starts on the current rising edge, returns on the first edge out of reset
    task automatic apply_reset();
        tb_rst <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_125mhz_int);
        tb_rst <= 1'b0;
        @(posedge clk_125mhz_int);
    endtask

    task automatic expect_idle(input string name);
        check_flag({name, " mdio_t after reset"}, 1'b1, mdio_t);
        check_flag({name, " mdc after reset"}, 1'b0, mdc);
        check_flag({name, " done after reset"}, 1'b0, done);
    endtask

    task automatic wait_bus_busy();
        while (mdio_t !== 1'b0) @(posedge clk_125mhz_int);
    endtask

    task automatic collect_frame();
        @(posedge clk_125mhz_int);
        while (mon_valid !== 1'b1) @(posedge clk_125mhz_int);
    endtask

    // With stop_at > 0 the walk ends partway into that frame
    task automatic run_frames(input string name, input int stop_at);
        string fname;
        for (int k = 1; k <= FRAME_COUNT; k++) begin
            fname = $sformatf("%s frame %0d", name, k);
            wait_bus_busy();
            if (k == stop_at) begin
                repeat (ABORT_OFFSET) @(posedge clk_125mhz_int);
                return;
            end
            collect_frame();
            check_count({fname, " bit count"}, TOTAL_BITS, mon_bits);
            check_flag({fname, " preamble"}, 1'b1, mon_preamble_ok);
            check_frame(fname, expected[k - 1], mon_frame);
            // 12th command is taken as frame 11 ends
            if (k <= FRAME_COUNT - 2) begin
                check_flag({fname, " done early"}, 1'b0, done);
            end
        end
        check_flag({name, " done after last frame"}, 1'b1, done);
    endtask

    task automatic watch_quiet_window(input string name);
        int frames;
        frames = 0;
        repeat (QUIET_CYCLES) begin
            @(posedge clk_125mhz_int);
            if (mon_valid === 1'b1) begin
                frames++;
            end
            check_flag({name, " bus idle after done"}, 1'b1, mdio_t);
            check_flag({name, " done held"}, 1'b1, done);
        end
        check_count({name, " frames after done"}, 0, frames);
    endtask

    // Cycles since the last reset, each run must end well before the limit
    always @(posedge clk_125mhz_int) begin
        if (dut_rst) begin
            run_cycles <= 0;
        end else if (run_cycles >= TIMEOUT_CYCLES) begin
            stop_run($sformatf("Timeout: the PHY init sequence never finished in %0d cycles",
                               TIMEOUT_CYCLES));
        end else begin
            run_cycles <= run_cycles + 1;
        end
    end

    initial begin
        logic [15:0] lfsr;
        logic [3:0]  pick;
        int          reset_at;

        tb_rst     = 1'b0;
        run_cycles = 0;
        build_tables();

        // One LFSR step per bit taken
        lfsr = LFSR_SEED;
        pick = '0;
        for (int b = 0; b < 4; b++) begin
            lfsr = lfsr_next(lfsr);
            pick = {pick[2:0], lfsr[0]};
        end
        reset_at = (int'(pick) % FRAME_COUNT) + 1;
        $display("Mid-sequence reset during frame %0d", reset_at);

        @(posedge clk_125mhz_int);
        while (por_rst !== 1'b0) @(posedge clk_125mhz_int);

        for (int p = 0; p < 2; p++) begin
            if (stim_table[p].mid_reset) begin
                // Restart, then abort inside the chosen frame
                apply_reset();
                expect_idle(stim_table[p].name);
                run_frames(stim_table[p].name, reset_at);
                apply_reset();
            end
            expect_idle(stim_table[p].name);
            run_frames(stim_table[p].name, 0);
            watch_quiet_window(stim_table[p].name);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule
